//--- bridge_macros.svh
// Width and depth macros for the NoC to AXI-Stream link
// Flit widths, derived byte counts and transmit FIFO depth
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// Narrow request and response payload
`define NARROW_FLIT_W 32
// Wide payload, also the link data field
`define WIDE_FLIT_W 64

// Byte counts, link strobe is WIDE_BYTES wide
`define NARROW_BYTES (`NARROW_FLIT_W / 8)
`define WIDE_BYTES (`WIDE_FLIT_W / 8)

// Entries in the transmit output FIFO
`define TX_FIFO_DEPTH 2

`endif

//--- noc_flit_pkg.sv
// NoC-side types
// Channel header encoding and narrow and wide flit payloads
`default_nettype none
`include "bridge_macros.svh"

package noc_flit_pkg;

  // Header carried with every link beat
  // Encoding 2'd3 is unused
  typedef enum logic [1:0] {
    HDR_NARROW_REQ = 2'd0,
    HDR_NARROW_RSP = 2'd1,
    HDR_WIDE       = 2'd2
  } chan_hdr_e;

  // Narrow request and response payload
  typedef logic [`NARROW_FLIT_W-1:0] narrow_flit_t;

  // Wide channel payload
  typedef logic [`WIDE_FLIT_W-1:0] wide_flit_t;

endpackage

`default_nettype wire

//--- axis_link_pkg.sv
// Link-side types
// Link beat layout and transmit selector state
`default_nettype none
`include "bridge_macros.svh"

package axis_link_pkg;
  import noc_flit_pkg::*;

  // One link beat, also one transmit FIFO entry
  // Narrow payloads sit zero-extended in the low bytes
  typedef struct packed {
    chan_hdr_e               hdr;
    logic [`WIDE_FLIT_W-1:0] data;
  } link_beat_t;

  // Transmit selector, narrow stream or wide stream
  typedef enum logic {
    SEL_NARROW = 1'b0,
    SEL_WIDE   = 1'b1
  } chan_sel_e;

endpackage

`default_nettype wire

//--- axis_stream_if.sv
// Chip-to-chip link interface
// Valid/ready handshake with beat data and byte strobe
`default_nettype none
`include "bridge_macros.svh"

interface axis_stream_if import axis_link_pkg::*; ();

  logic                   tvalid;
  logic                   tready;
  // Header plus payload
  link_beat_t             tdata;
  // Bytes of tdata.data that carry payload
  logic [`WIDE_BYTES-1:0] tstrb;

  // Transmit side
  modport sender (output tvalid, output tdata, output tstrb, input tready);

  // Receive side
  modport receiver (input tvalid, input tdata, input tstrb, output tready);

endinterface

`default_nettype wire

//--- narrow_rr_arbiter.sv
// Round-robin arbiter for the narrow request and response channels
// Combinational grant, one-bit priority, grant held while stalled
`default_nettype none

module narrow_rr_arbiter import noc_flit_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         req_valid_i,
  input  narrow_flit_t req_data_i,
  output logic         req_ready_o,
  input  logic         rsp_valid_i,
  input  narrow_flit_t rsp_data_i,
  output logic         rsp_ready_o,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output narrow_flit_t out_data_o,
  output chan_hdr_e    out_hdr_o
);

  // Set when the response channel won the last transfer
  logic last_rsp_q;
  // Stalled grant kept until its transfer
  logic hold_q;
  logic hold_rsp_q;
  // Current choice where 1 selects response
  logic pick_rsp;

  always_comb begin
    if (hold_q) begin
      pick_rsp = hold_rsp_q;
    end else if (req_valid_i && rsp_valid_i) begin
      // Both waiting so take turns
      pick_rsp = ~last_rsp_q;
    end else begin
      pick_rsp = rsp_valid_i;
    end
  end

  assign out_valid_o = pick_rsp ? rsp_valid_i : req_valid_i;
  assign out_data_o  = pick_rsp ? rsp_data_i : req_data_i;
  assign out_hdr_o   = pick_rsp ? HDR_NARROW_RSP : HDR_NARROW_REQ;
  assign req_ready_o = ~pick_rsp & out_ready_i;
  assign rsp_ready_o = pick_rsp & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Request channel goes first after reset
      last_rsp_q <= 1'b1;
      hold_q     <= 1'b0;
      hold_rsp_q <= 1'b0;
    end else begin
      hold_q     <= out_valid_o & ~out_ready_i;
      hold_rsp_q <= pick_rsp;
      // Priority moves only on a completed transfer
      if (out_valid_o && out_ready_i) begin
        last_rsp_q <= pick_rsp;
      end
    end
  end

  // A stalled grant keeps its channel and its flit on the next edge
  a_grant_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=>
      out_valid_o && out_hdr_o == $past(out_hdr_o) && $stable(out_data_o))
    else $error("narrow grant switched while output stalled");

endmodule

`default_nettype wire

//--- axis_tx_mux.sv
// Transmit selector between narrow and wide streams
// Selector FSM, two-entry output FIFO, strobe from FIFO head
`default_nettype none
`include "bridge_macros.svh"

module axis_tx_mux import noc_flit_pkg::*, axis_link_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         nar_valid_i,
  output logic         nar_ready_o,
  input  narrow_flit_t nar_data_i,
  input  chan_hdr_e    nar_hdr_i,
  input  logic         wide_valid_i,
  output logic         wide_ready_o,
  input  wide_flit_t   wide_data_i,
  axis_stream_if.sender link
);

  localparam int PTR_W = (`TX_FIFO_DEPTH > 1) ? $clog2(`TX_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(`TX_FIFO_DEPTH + 1);

  chan_sel_e        sel_q;
  chan_sel_e        sel_d;
  logic             in_valid;
  link_beat_t       in_beat;
  logic             fifo_space;
  logic             push;
  logic             pop;
  link_beat_t       mem [`TX_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  ////////////////////////////////////////////////////////////
  // Selector FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    sel_d        = sel_q;
    in_valid     = 1'b0;
    nar_ready_o  = 1'b0;
    wide_ready_o = 1'b0;
    // Narrow beat, zero-extended into the link word
    in_beat.hdr  = nar_hdr_i;
    in_beat.data = {{(`WIDE_FLIT_W - `NARROW_FLIT_W){1'b0}}, nar_data_i};
    case (sel_q)
      SEL_NARROW: begin
        in_valid    = nar_valid_i;
        nar_ready_o = fifo_space;
        // Narrow idle with wide waiting
        if (wide_valid_i && !nar_valid_i) begin
          sel_d = SEL_WIDE;
        end
      end
      SEL_WIDE: begin
        in_beat.hdr  = HDR_WIDE;
        in_beat.data = wide_data_i;
        in_valid     = wide_valid_i;
        wide_ready_o = fifo_space;
        // Wide idle or just accepted, narrow waiting
        if ((!wide_valid_i || fifo_space) && nar_valid_i) begin
          sel_d = SEL_NARROW;
        end
      end
      default: sel_d = SEL_NARROW;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output FIFO
  ////////////////////////////////////////////////////////////

  assign fifo_space = (count_q != CNT_W'(`TX_FIFO_DEPTH));
  assign push       = in_valid & fifo_space;
  assign pop        = link.tvalid & link.tready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q    <= SEL_NARROW;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      sel_q <= sel_d;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`TX_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`TX_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_beat;
    end
  end

  assign link.tvalid = (count_q != '0);
  assign link.tdata  = mem[rd_ptr_q];
  // Low bytes only for narrow beats
  assign link.tstrb  = (mem[rd_ptr_q].hdr == HDR_WIDE) ? {`WIDE_BYTES{1'b1}} :
                       {{(`WIDE_BYTES - `NARROW_BYTES){1'b0}}, {`NARROW_BYTES{1'b1}}};

  // Offered beat holds until taken
  a_link_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link.tvalid && !link.tready |=>
      link.tvalid && $stable(link.tdata) && $stable(link.tstrb))
    else $error("link beat changed before transfer");

endmodule

`default_nettype wire

//--- noc_axis_bridge.sv
// One NoC to AXI-Stream bridge
// Transmit arbiter and selector, receive header decode and byte masking
`default_nettype none
`include "bridge_macros.svh"

module noc_axis_bridge import noc_flit_pkg::*, axis_link_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  // NoC to link
  input  logic         nreq_valid_i,
  output logic         nreq_ready_o,
  input  narrow_flit_t nreq_data_i,
  input  logic         nrsp_valid_i,
  output logic         nrsp_ready_o,
  input  narrow_flit_t nrsp_data_i,
  input  logic         wide_valid_i,
  output logic         wide_ready_o,
  input  wide_flit_t   wide_data_i,
  // Link to NoC
  output logic         nreq_valid_o,
  input  logic         nreq_ready_i,
  output narrow_flit_t nreq_data_o,
  output logic         nrsp_valid_o,
  input  logic         nrsp_ready_i,
  output narrow_flit_t nrsp_data_o,
  output logic         wide_valid_o,
  input  logic         wide_ready_i,
  output wide_flit_t   wide_data_o,
  axis_stream_if.sender   tx_link,
  axis_stream_if.receiver rx_link
);

  // Arbiter to selector
  logic         nar_valid;
  logic         nar_ready;
  narrow_flit_t nar_data;
  chan_hdr_e    nar_hdr;
  // Receive side
  link_beat_t   rx_beat;
  wide_flit_t   rx_masked;
  logic         rx_ready;

  ////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////

  narrow_rr_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (nreq_valid_i),
    .req_data_i  (nreq_data_i),
    .req_ready_o (nreq_ready_o),
    .rsp_valid_i (nrsp_valid_i),
    .rsp_data_i  (nrsp_data_i),
    .rsp_ready_o (nrsp_ready_o),
    .out_valid_o (nar_valid),
    .out_ready_i (nar_ready),
    .out_data_o  (nar_data),
    .out_hdr_o   (nar_hdr)
  );

  axis_tx_mux u_tx_mux (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .nar_valid_i  (nar_valid),
    .nar_ready_o  (nar_ready),
    .nar_data_i   (nar_data),
    .nar_hdr_i    (nar_hdr),
    .wide_valid_i (wide_valid_i),
    .wide_ready_o (wide_ready_o),
    .wide_data_i  (wide_data_i),
    .link         (tx_link)
  );

  ////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////

  assign rx_beat = rx_link.tdata;

  // Clear bytes the strobe does not cover
  always_comb begin
    for (int i = 0; i < `WIDE_BYTES; i++) begin
      rx_masked[i*8 +: 8] = rx_link.tstrb[i] ? rx_beat.data[i*8 +: 8] : 8'h00;
    end
  end

  // Steer by header
  assign nreq_valid_o = rx_link.tvalid && (rx_beat.hdr == HDR_NARROW_REQ);
  assign nrsp_valid_o = rx_link.tvalid && (rx_beat.hdr == HDR_NARROW_RSP);
  assign wide_valid_o = rx_link.tvalid && (rx_beat.hdr == HDR_WIDE);
  assign nreq_data_o  = rx_masked[`NARROW_FLIT_W-1:0];
  assign nrsp_data_o  = rx_masked[`NARROW_FLIT_W-1:0];
  assign wide_data_o  = rx_masked;

  // Link ready only from the addressed channel
  always_comb begin
    case (rx_beat.hdr)
      HDR_NARROW_REQ: rx_ready = nreq_ready_i;
      HDR_NARROW_RSP: rx_ready = nrsp_ready_i;
      HDR_WIDE:       rx_ready = wide_ready_i;
      default:        rx_ready = 1'b0;
    endcase
  end

  assign rx_link.tready = rx_ready;

  // Far-side strobe agrees with the header it was sent with
  a_strb_hdr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_link.tvalid |-> ((rx_beat.hdr == HDR_WIDE) ? (&rx_link.tstrb) :
      (&rx_link.tstrb[`NARROW_BYTES-1:0] &&
       rx_link.tstrb[`WIDE_BYTES-1:`NARROW_BYTES] == '0)))
    else $error("link strobe does not match beat header");

endmodule

`default_nettype wire

//--- noc_link_top.sv
// Top level of the chip-to-chip link
// Bridges A and B joined through two link interfaces
`default_nettype none

module noc_link_top import noc_flit_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  // Side A, NoC into the link
  input  logic         a_nreq_valid_i, a_nrsp_valid_i, a_wide_valid_i,
  output logic         a_nreq_ready_o, a_nrsp_ready_o, a_wide_ready_o,
  input  narrow_flit_t a_nreq_data_i, a_nrsp_data_i,
  input  wide_flit_t   a_wide_data_i,
  // Side A, link out to the NoC
  output logic         a_nreq_valid_o, a_nrsp_valid_o, a_wide_valid_o,
  input  logic         a_nreq_ready_i, a_nrsp_ready_i, a_wide_ready_i,
  output narrow_flit_t a_nreq_data_o, a_nrsp_data_o,
  output wide_flit_t   a_wide_data_o,
  // Side B, NoC into the link
  input  logic         b_nreq_valid_i, b_nrsp_valid_i, b_wide_valid_i,
  output logic         b_nreq_ready_o, b_nrsp_ready_o, b_wide_ready_o,
  input  narrow_flit_t b_nreq_data_i, b_nrsp_data_i,
  input  wide_flit_t   b_wide_data_i,
  // Side B, link out to the NoC
  output logic         b_nreq_valid_o, b_nrsp_valid_o, b_wide_valid_o,
  input  logic         b_nreq_ready_i, b_nrsp_ready_i, b_wide_ready_i,
  output narrow_flit_t b_nreq_data_o, b_nrsp_data_o,
  output wide_flit_t   b_wide_data_o
);

  // A to B and B to A
  axis_stream_if link_ab ();
  axis_stream_if link_ba ();

  noc_axis_bridge bridge_a (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .nreq_valid_i (a_nreq_valid_i), .nreq_ready_o (a_nreq_ready_o), .nreq_data_i (a_nreq_data_i),
    .nrsp_valid_i (a_nrsp_valid_i), .nrsp_ready_o (a_nrsp_ready_o), .nrsp_data_i (a_nrsp_data_i),
    .wide_valid_i (a_wide_valid_i), .wide_ready_o (a_wide_ready_o), .wide_data_i (a_wide_data_i),
    .nreq_valid_o (a_nreq_valid_o), .nreq_ready_i (a_nreq_ready_i), .nreq_data_o (a_nreq_data_o),
    .nrsp_valid_o (a_nrsp_valid_o), .nrsp_ready_i (a_nrsp_ready_i), .nrsp_data_o (a_nrsp_data_o),
    .wide_valid_o (a_wide_valid_o), .wide_ready_i (a_wide_ready_i), .wide_data_o (a_wide_data_o),
    .tx_link (link_ab), .rx_link (link_ba)
  );

  noc_axis_bridge bridge_b (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .nreq_valid_i (b_nreq_valid_i), .nreq_ready_o (b_nreq_ready_o), .nreq_data_i (b_nreq_data_i),
    .nrsp_valid_i (b_nrsp_valid_i), .nrsp_ready_o (b_nrsp_ready_o), .nrsp_data_i (b_nrsp_data_i),
    .wide_valid_i (b_wide_valid_i), .wide_ready_o (b_wide_ready_o), .wide_data_i (b_wide_data_i),
    .nreq_valid_o (b_nreq_valid_o), .nreq_ready_i (b_nreq_ready_i), .nreq_data_o (b_nreq_data_o),
    .nrsp_valid_o (b_nrsp_valid_o), .nrsp_ready_i (b_nrsp_ready_i), .nrsp_data_o (b_nrsp_data_o),
    .wide_valid_o (b_wide_valid_o), .wide_ready_i (b_wide_ready_i), .wide_data_o (b_wide_data_o),
    .tx_link (link_ba), .rx_link (link_ab)
  );

endmodule

`default_nettype wire

//--- tb_noc_link.sv
// Testbench for the two-bridge NoC link
// Random traffic driver, per-channel scoreboard, handshake checks
`default_nettype none

module tb_noc_link import noc_flit_pkg::*; ();

  localparam int PHASE_TIMEOUT = 2000;

  // Index k is side * 3 plus channel with 0 req, 1 rsp and 2 wide
  logic              clk_i;
  logic              rst_n_i;
  logic [5:0]        in_valid;
  wide_flit_t        in_data [6];
  logic [5:0]        out_ready;
  wire  [5:0]        in_ready;
  wire  [5:0]        out_valid;
  wire narrow_flit_t out_nd [4];
  wire wide_flit_t   out_word [6];

  integer     seed = 1;
  int         errors = 0;
  int         sent = 0;
  int         recv = 0;
  int         cycle = 0;
  // Flits asked for and flits offered per input channel
  int         quota [6] = '{default: 0};
  int         issued [6] = '{default: 0};
  int         vpct = 0;
  int         rpct = 100;
  int         last_nar = -1;
  logic       check_latency = 1'b0;
  logic       check_alternate = 1'b0;
  logic       first_sent = 1'b0;
  // Input transfer due on the coming edge
  logic [5:0] acc = '0;
  logic [5:0] cur_valid = '0;
  string      test_name = "reset";
  wide_flit_t cur_word [6];
  wide_flit_t prev_word [6];
  // Scoreboard indexed by sending channel
  wide_flit_t exp_q [6][$];
  int         cyc_q [6][$];

  noc_link_top dut_i (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .a_nreq_valid_i (in_valid[0]), .a_nreq_ready_o (in_ready[0]),
    .a_nreq_data_i (narrow_flit_t'(in_data[0])),
    .a_nrsp_valid_i (in_valid[1]), .a_nrsp_ready_o (in_ready[1]),
    .a_nrsp_data_i (narrow_flit_t'(in_data[1])),
    .a_wide_valid_i (in_valid[2]), .a_wide_ready_o (in_ready[2]), .a_wide_data_i (in_data[2]),
    .a_nreq_valid_o (out_valid[0]), .a_nreq_ready_i (out_ready[0]), .a_nreq_data_o (out_nd[0]),
    .a_nrsp_valid_o (out_valid[1]), .a_nrsp_ready_i (out_ready[1]), .a_nrsp_data_o (out_nd[1]),
    .a_wide_valid_o (out_valid[2]), .a_wide_ready_i (out_ready[2]), .a_wide_data_o (out_word[2]),
    .b_nreq_valid_i (in_valid[3]), .b_nreq_ready_o (in_ready[3]),
    .b_nreq_data_i (narrow_flit_t'(in_data[3])),
    .b_nrsp_valid_i (in_valid[4]), .b_nrsp_ready_o (in_ready[4]),
    .b_nrsp_data_i (narrow_flit_t'(in_data[4])),
    .b_wide_valid_i (in_valid[5]), .b_wide_ready_o (in_ready[5]), .b_wide_data_i (in_data[5]),
    .b_nreq_valid_o (out_valid[3]), .b_nreq_ready_i (out_ready[3]), .b_nreq_data_o (out_nd[2]),
    .b_nrsp_valid_o (out_valid[4]), .b_nrsp_ready_i (out_ready[4]), .b_nrsp_data_o (out_nd[3]),
    .b_wide_valid_o (out_valid[5]), .b_wide_ready_i (out_ready[5]), .b_wide_data_o (out_word[5])
  );

  // Narrow outputs seen as zero-extended link words
  assign out_word[0] = wide_flit_t'(out_nd[0]);
  assign out_word[1] = wide_flit_t'(out_nd[1]);
  assign out_word[3] = wide_flit_t'(out_nd[2]);
  assign out_word[4] = wide_flit_t'(out_nd[3]);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic int roll();
    return ($random(seed) & 32'h7fff_ffff) % 100;
  endfunction

  function automatic wide_flit_t new_flit(input int k);
    if (k % 3 == 2) begin
      return wide_flit_t'({$random(seed), $random(seed)});
    end
    return wide_flit_t'(narrow_flit_t'($random(seed)));
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (rst_n_i) begin
      for (int k = 0; k < 6; k++) begin
        // New offer only once the previous one is taken
        if (!in_valid[k] || acc[k]) begin
          if (issued[k] < quota[k] && roll() < vpct) begin
            in_valid[k] <= 1'b1;
            in_data[k]  <= new_flit(k);
            issued[k]   <= issued[k] + 1;
            first_sent  <= 1'b1;
          end else begin
            in_valid[k] <= 1'b0;
          end
        end
        // Far-side ready gaps
        out_ready[k] <= (roll() < rpct);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor and scoreboard on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic check_arrival(input int j);
    int         src;
    int         ch;
    int         acc_cyc;
    wide_flit_t exp_v;
    // Side A outputs carry side B traffic and back
    src = (j < 3) ? j + 3 : j - 3;
    ch  = j % 3;
    recv++;
    if (exp_q[src].size() == 0) begin
      errors++;
      $display("Flit on output %0d in %s was never sent", j, test_name);
    end else begin
      exp_v   = exp_q[src].pop_front();
      acc_cyc = cyc_q[src].pop_front();
      a_data: assert (out_word[j] == exp_v) else begin
        errors++;
        $display("Fail %s: output %0d expected %h, got %h", test_name, j, exp_v, out_word[j]);
      end
      // One cycle through an idle link
      if (check_latency) begin
        a_latency: assert (cycle == acc_cyc + 1) else begin
          errors++;
          $display("Fail %s: arrival cycle expected %0d, got %0d", test_name, acc_cyc + 1, cycle);
        end
      end
    end
    if (check_alternate && ch != 2) begin
      a_alternate: assert (ch != last_nar) else begin
        errors++;
        $display("Fail %s: narrow channel expected %0d, got %0d", test_name, 1 - ch, ch);
      end
      last_nar = ch;
    end
  endtask

  always @(negedge clk_i) begin
    cur_valid = out_valid;
    for (int j = 0; j < 6; j++) begin
      prev_word[j] = cur_word[j];
      cur_word[j]  = out_word[j];
      acc[j] = rst_n_i && in_valid[j] && in_ready[j];
      if (acc[j]) begin
        exp_q[j].push_back(in_data[j]);
        cyc_q[j].push_back(cycle);
        sent++;
      end
      if (rst_n_i && out_valid[j] && out_ready[j]) begin
        check_arrival(j);
      end
    end
  end

  // Nothing comes out before the first flit goes in
  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !first_sent |-> out_valid == '0)
    else begin
      errors++;
      $display("Fail reset: expected valids 000000, got %b", cur_valid);
    end

  // Stalled outputs hold valid and data
  for (genvar j = 0; j < 6; j++) begin : g_hold
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid[j] && !out_ready[j] |=> out_valid[j] && $stable(out_word[j]))
      else begin
        errors++;
        $display("Fail %s: stalled output %0d expected %h, got %h",
                 test_name, j, prev_word[j], cur_word[j]);
      end
  end

  ////////////////////////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////////////////////////

  function automatic logic drained();
    logic done;
    done = (in_valid == '0);
    for (int k = 0; k < 6; k++) begin
      if (issued[k] != quota[k] || exp_q[k].size() != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic run_phase(input string name, input logic [5:0] mask, input int count,
                           input int v_pct, input int r_pct, input logic lat, input logic alt);
    int waited;
    int recv0;
    int n_exp;
    // Link is empty here, so the monitor sees no traffic on this edge
    @(negedge clk_i);
    test_name       = name;
    vpct            = v_pct;
    rpct            = r_pct;
    check_latency   = lat;
    check_alternate = alt;
    last_nar        = -1;
    recv0           = recv;
    n_exp           = count * $countones(mask);
    for (int k = 0; k < 6; k++) begin
      if (mask[k]) begin
        quota[k] = quota[k] + count;
      end
    end
    waited = 0;
    @(posedge clk_i);
    while (!drained() && waited < PHASE_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (!drained()) begin
      errors++;
      $display("Timeout in %s: not every flit reached the far side", name);
    end
    a_count: assert (recv - recv0 == n_exp) else begin
      errors++;
      $display("Fail %s: expected %0d flits delivered, got %0d", name, n_exp, recv - recv0);
    end
  endtask

  initial begin
    rst_n_i   = 1'b0;
    in_valid  = '0;
    out_ready = '0;
    for (int k = 0; k < 6; k++) begin
      in_data[k] = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Idle outputs after reset
    repeat (6) @(posedge clk_i);
    for (int k = 0; k < 6; k++) begin
      run_phase("single", 6'b1 << k, 1, 100, 100, 1'b1, 1'b0);
    end
    run_phase("fairness", 6'b000011, 16, 100, 100, 1'b0, 1'b1);
    run_phase("sharing", 6'b000111, 24, 60, 100, 1'b0, 1'b0);
    run_phase("backpressure", 6'b000111, 24, 70, 50, 1'b0, 1'b0);
    run_phase("duplex", 6'b111111, 24, 50, 60, 1'b0, 1'b0);
    $display("Errors: %0d, flits sent %0d, received %0d", errors, sent, recv);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
noc_flit_pkg.sv
axis_link_pkg.sv
axis_stream_if.sv
narrow_rr_arbiter.sv
axis_tx_mux.sv
noc_axis_bridge.sv
noc_link_top.sv
tb_noc_link.sv

//--- Makefile
# Verilator build and run for the NoC link testbench

VERILATOR ?= verilator
TOP       ?= tb_noc_link
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
